//--- capture_defs.svh
/*
 * capture sizing constants
 * shared by the packer, the capture bank and the readout framer
 */
`ifndef CAPTURE_DEFS_SVH
`define CAPTURE_DEFS_SVH

// words held by the bank, kept small for short simulated captures
`define BANK_DEPTH 16

// adc samples packed side by side into one bank word
`define SAMPLES_PER_WORD 4

// bits per adc sample
`define SAMPLE_WIDTH 12

// framer queue depth, also the bank's starting credit count
`define READ_CREDITS 4

// width of the channel identifier written into the first beat
`define CHANNEL_ID_WIDTH 4

`endif

//--- capture_pkg.sv
/*
 * capture side types
 * one adc sample, one packed bank word and the captured word count
 */
`include "capture_defs.svh"

package capture_pkg;

  // raw adc sample
  typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

  // packed word, sample 0 sits in the lowest bits
  typedef logic [`SAMPLES_PER_WORD*`SAMPLE_WIDTH-1:0] word_t;

  // number of stored words
  // one bit wider than the address so a full bank can be reported
  typedef logic [$clog2(`BANK_DEPTH + 1)-1:0] count_t;

endpackage

//--- capture_top.sv
/*
 * capture top level
 * adc samples go through the packer into the bank, records come back
 * through the framer onto the valid/ready output
 */
`timescale 1ns/1ps
`include "capture_defs.svh"

module capture_top
  import capture_pkg::*;
  import readout_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic                         stop,
  input  logic [`CHANNEL_ID_WIDTH-1:0] channel_id,
  input  logic                         sample_valid,
  input  sample_t                      sample_data,
  input  logic                         out_ready,
  output logic                         bank_full,
  output logic                         out_valid,
  output beat_t                        out_data,
  output logic                         out_last,
  output logic                         out_first
);

  // packer to bank, no back-pressure
  logic  word_valid;
  word_t word_data;

  // bank to framer, credit flow
  logic       beat_valid;
  beat_t      beat_data;
  beat_kind_t beat_kind;
  logic       beat_last;
  logic       credit_return;

  sample_packer packer (
    .clk          (clk),
    .reset        (reset),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .word_valid   (word_valid),
    .word_data    (word_data)
  );

  sample_bank bank (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .stop          (stop),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .credit_return (credit_return),
    .bank_full     (bank_full),
    .beat_valid    (beat_valid),
    .beat_data     (beat_data),
    .beat_kind     (beat_kind),
    .beat_last     (beat_last)
  );

  readout_framer framer (
    .clk           (clk),
    .reset         (reset),
    .channel_id    (channel_id),
    .beat_valid    (beat_valid),
    .beat_data     (beat_data),
    .beat_kind     (beat_kind),
    .beat_last     (beat_last),
    .out_ready     (out_ready),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_last      (out_last),
    .out_first     (out_first)
  );

endmodule

//--- readout_framer.sv
/*
 * readout framer
 * queues beats from the bank, puts the channel identifier into the first
 * beat of each record and hands beats out on a valid/ready port
 * every transfer returns one credit to the bank
 */
`timescale 1ns/1ps
`include "capture_defs.svh"

module readout_framer
  import readout_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`CHANNEL_ID_WIDTH-1:0] channel_id,
  input  logic                         beat_valid,
  input  beat_t                        beat_data,
  input  beat_kind_t                   beat_kind,
  input  logic                         beat_last,
  input  logic                         out_ready,
  output logic                         credit_return,
  output logic                         out_valid,
  output beat_t                        out_data,
  output logic                         out_last,
  output logic                         out_first
);

  localparam int DEPTH = `READ_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  beat_t            q_data [DEPTH];
  logic [DEPTH-1:0] q_last;
  logic [DEPTH-1:0] q_first;

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;

  logic  is_id;
  logic  pop;
  beat_t wr_data;

  // queue pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // identifier beat gets the channel number, zero-extended
  assign is_id   = (beat_kind == BEAT_ID);
  assign wr_data = is_id ? beat_t'(channel_id) : beat_data;

  // head of the queue drives the output directly
  assign out_valid = (fill != '0);
  assign out_data  = q_data[rd_ptr];
  assign out_last  = q_last[rd_ptr];
  assign out_first = q_first[rd_ptr];
  assign pop       = out_valid && out_ready;

  // storage, credits guarantee a free slot for every incoming beat
  always_ff @(posedge clk) begin
    if (beat_valid) begin
      q_data[wr_ptr]  <= wr_data;
      q_last[wr_ptr]  <= beat_last;
      q_first[wr_ptr] <= is_id;
    end
  end

  // pointers, fill level and credit return
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill          <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;
      if (beat_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      unique case ({beat_valid, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

endmodule

//--- readout_pkg.sv
/*
 * readout side types
 * beat kinds of a record and the width of one readout beat
 */
`include "capture_defs.svh"

package readout_pkg;

  // a beat is as wide as one packed word
  localparam int BEAT_WIDTH = `SAMPLES_PER_WORD * `SAMPLE_WIDTH;

  // record layout is identifier, count, then the stored words
  typedef enum logic [1:0] {
    BEAT_ID,
    BEAT_COUNT,
    BEAT_SAMPLE
  } beat_kind_t;

  // readout data, header values are zero-extended into it
  typedef logic [BEAT_WIDTH-1:0] beat_t;

endpackage

//--- sample_bank.sv
/*
 * capture bank
 * stores packed words between start and stop or until full, then reads out
 * an identifier beat, a count beat and the stored words
 * beats are issued against credits returned by the downstream queue
 */
`timescale 1ns/1ps
`include "capture_defs.svh"

module sample_bank
  import capture_pkg::*;
  import readout_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  logic       stop,
  input  logic       word_valid,
  input  word_t      word_data,
  input  logic       credit_return,
  output logic       bank_full,
  output logic       beat_valid,
  output beat_t      beat_data,
  output beat_kind_t beat_kind,
  output logic       beat_last
);

  localparam int DEPTH    = `BANK_DEPTH;
  localparam int ADDR_W   = $clog2(DEPTH);
  localparam int CREDIT_W = $clog2(`READ_CREDITS + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_CAPTURE,
    S_SEND_ID,
    S_SEND_COUNT,
    S_SEND_SAMPLES
  } state_t;

  state_t state;

  word_t mem [DEPTH];

  // word_count doubles as the write pointer
  count_t word_count;
  count_t rd_count;
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;

  logic [CREDIT_W-1:0] credits;
  logic store;
  logic issue;
  logic last_read;

  // registered memory word and header word, picked by the beat kind
  word_t rd_word;
  beat_t hdr_word;

  assign wr_addr = word_count[ADDR_W-1:0];
  assign rd_addr = rd_count[ADDR_W-1:0];

  // words outside capture are simply dropped, the adc cannot be stalled
  assign store = (state == S_CAPTURE) && word_valid;

  // any send state issues one beat per cycle while a credit is held
  assign issue = (credits != '0) &&
                 (state inside {S_SEND_ID, S_SEND_COUNT, S_SEND_SAMPLES});

  assign last_read = (rd_count == word_count - 1'b1);

  assign beat_data = (beat_kind == BEAT_SAMPLE) ? rd_word : hdr_word;

  // memory port, read data lands one cycle after the read is issued
  always_ff @(posedge clk) begin
    if (store) begin
      mem[wr_addr] <= word_data;
    end
    if (issue && (state == S_SEND_SAMPLES)) begin
      rd_word <= mem[rd_addr];
    end
  end

  // header payload, identifier is left zero for the framer to fill in
  always_ff @(posedge clk) begin
    if (issue && (state == S_SEND_ID)) begin
      hdr_word <= '0;
    end else if (issue && (state == S_SEND_COUNT)) begin
      hdr_word <= beat_t'(word_count);
    end
  end

  // capture and readout sequencing
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= S_IDLE;
      word_count <= '0;
      rd_count   <= '0;
      bank_full  <= 1'b0;
      beat_valid <= 1'b0;
      beat_kind  <= BEAT_ID;
      beat_last  <= 1'b0;
    end else begin
      beat_valid <= issue;
      beat_last  <= 1'b0;
      unique case (state)
        S_IDLE: begin
          rd_count <= '0;
          if (start) begin
            word_count <= '0;
            state      <= S_CAPTURE;
          end
        end
        S_CAPTURE: begin
          // a word arriving with stop is still kept
          if (stop) begin
            state <= S_SEND_ID;
          end
          if (store) begin
            word_count <= word_count + 1'b1;
            if (word_count == count_t'(DEPTH - 1)) begin
              bank_full <= 1'b1;
              state     <= S_SEND_ID;
            end
          end
        end
        S_SEND_ID: begin
          if (issue) begin
            beat_kind <= BEAT_ID;
            state     <= S_SEND_COUNT;
          end
        end
        S_SEND_COUNT: begin
          if (issue) begin
            beat_kind <= BEAT_COUNT;
            // empty capture ends the record on the count beat
            if (word_count == '0) begin
              beat_last <= 1'b1;
              bank_full <= 1'b0;
              state     <= S_IDLE;
            end else begin
              state <= S_SEND_SAMPLES;
            end
          end
        end
        S_SEND_SAMPLES: begin
          // read pointer holds whenever credits run out
          if (issue) begin
            beat_kind <= BEAT_SAMPLE;
            rd_count  <= rd_count + 1'b1;
            if (last_read) begin
              beat_last <= 1'b1;
              bank_full <= 1'b0;
              state     <= S_IDLE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // credit counter, one spent per issued beat and one back per return pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CREDIT_W'(`READ_CREDITS);
    end else begin
      unique case ({issue, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

//--- sample_packer.sv
/*
 * sample packer
 * collects SAMPLES_PER_WORD consecutive adc samples into one parallel word
 * and pulses word_valid for one cycle when the word is complete
 */
`timescale 1ns/1ps
`include "capture_defs.svh"

module sample_packer
  import capture_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    sample_valid,
  input  sample_t sample_data,
  output logic    word_valid,
  output word_t   word_data
);

  localparam int SPW    = `SAMPLES_PER_WORD;
  localparam int SLOT_W = (SPW > 1) ? $clog2(SPW) : 1;

  // lane that the next accepted sample goes into
  logic [SLOT_W-1:0] slot;
  logic              last_slot;

  assign last_slot = (slot == SLOT_W'(SPW - 1));

  // each sample lands in its own lane, sample 0 lowest
  // lanes are overwritten in order so the word is whole when word_valid fires
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      word_data[slot*`SAMPLE_WIDTH +: `SAMPLE_WIDTH] <= sample_data;
    end
  end

  // slot counter and word strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      slot       <= '0;
      word_valid <= 1'b0;
    end else begin
      // strobe follows the edge that took the last sample of a group
      word_valid <= sample_valid && last_slot;
      if (sample_valid) begin
        if (last_slot) begin
          slot <= '0;
        end else begin
          slot <= slot + 1'b1;
        end
      end
    end
  end

endmodule

//--- sim.f
+incdir+.
capture_pkg.sv
readout_pkg.sv
sample_packer.sv
sample_bank.sv
readout_framer.sv
capture_top.sv
tb_capture_top.sv

//--- tb_capture_top.sv
/*
 * capture top level testbench
 * random samples and out_ready back-pressure come from an xorshift generator
 * a cycle model of packing and capture builds the expected records
 */
`timescale 1ns/1ps
`include "capture_defs.svh"

module tb_capture_top
  import capture_pkg::*;
  import readout_pkg::*;
();

  localparam int CLK_PERIOD  = 10;
  localparam int SW          = `SAMPLE_WIDTH;
  localparam int SPW         = `SAMPLES_PER_WORD;
  localparam int KIND_STOP   = 0;
  localparam int KIND_FULL   = 1;
  localparam int KIND_EMPTY  = 2;
  localparam int NUM_RANDOM  = 30;
  localparam int NUM_RECORDS = 3 + NUM_RANDOM;
  // budget well above a 70 cycle capture plus 18 stalled beats and a gap of 7
  localparam int RECORD_CYCLES = 400;

  logic                         clk = 1'b0;
  logic                         reset;
  logic                         start;
  logic                         stop;
  logic [`CHANNEL_ID_WIDTH-1:0] channel_id;
  logic                         sample_valid;
  sample_t                      sample_data;
  logic                         out_ready;
  logic                         bank_full;
  logic                         out_valid;
  beat_t                        out_data;
  logic                         out_last;
  logic                         out_first;

  logic [31:0] rng = 32'h5ee9;
  int          records_done = 0;

  // packer model state
  int    m_slot = 0;
  word_t m_word = '0;
  bit    m_wv = 1'b0;
  word_t m_wv_data = '0;

  // bank model state
  bit    m_capturing = 1'b0;
  bit    full_check = 1'b0;
  word_t cap_words [$];

  // expected output beats in order
  beat_t exp_data [$];
  bit    exp_last [$];
  bit    exp_first [$];

  capture_top dut (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .stop         (stop),
    .channel_id   (channel_id),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .out_ready    (out_ready),
    .bank_full    (bank_full),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_last     (out_last),
    .out_first    (out_first)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("error: %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
      $display("TEST FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // queue the identifier, the count and the stored words of a finished capture
  task automatic close_record();
    int n;
    int i;
    n = cap_words.size();
    exp_data.push_back(beat_t'(channel_id));
    exp_last.push_back(1'b0);
    exp_first.push_back(1'b1);
    exp_data.push_back(beat_t'(n));
    exp_last.push_back(n == 0);
    exp_first.push_back(1'b0);
    for (i = 0; i < n; i++) begin
      exp_data.push_back(beat_t'(cap_words[i]));
      exp_last.push_back(i == n - 1);
      exp_first.push_back(1'b0);
    end
    m_capturing = 1'b0;
  endtask

  task automatic check_bank_full();
    // one edge after the filling word the flag must be up
    if (full_check) begin
      check_value("bank_full", bank_full, 1);
      full_check = 1'b0;
    end
    if (m_capturing) begin
      check_value("bank_full", bank_full, 0);
    end
  endtask

  task automatic compare_transfer();
    beat_t e_data;
    bit    e_last;
    bit    e_first;
    if (out_valid && out_ready) begin
      if (exp_data.size() == 0) begin
        $display("an output beat arrived while no record was expected at %0t", $time);
        $display("TEST FAILED");
        $fatal(1, "unexpected output beat");
      end else begin
        e_data  = exp_data.pop_front();
        e_last  = exp_last.pop_front();
        e_first = exp_first.pop_front();
        check_value("out_data", out_data, e_data);
        check_value("out_last", out_last, e_last);
        check_value("out_first", out_first, e_first);
        if (out_last) begin
          records_done++;
        end
      end
    end
  endtask

  task automatic model_cycle();
    // bank sees the word strobe registered at the previous edge
    if (m_capturing) begin
      if (m_wv) begin
        cap_words.push_back(m_wv_data);
        if (cap_words.size() == `BANK_DEPTH) begin
          full_check = 1'b1;
          close_record();
        end
      end
      if (m_capturing && stop) begin
        close_record();
      end
    end else if (start) begin
      m_capturing = 1'b1;
      cap_words.delete();
    end
    // packer with sample 0 of a group in the lowest lane
    m_wv = 1'b0;
    if (sample_valid) begin
      m_word[m_slot*SW +: SW] = sample_data;
      if (m_slot == SPW - 1) begin
        m_wv      = 1'b1;
        m_wv_data = m_word;
        m_slot    = 0;
      end else begin
        m_slot++;
      end
    end
  endtask

  // monitor runs before the model on the values held before the edge
  always @(posedge clk) begin
    if (!reset) begin
      check_bank_full();
      compare_transfer();
      model_cycle();
    end
  end

  // sample mode 0 sends none, 1 sends with random gaps, 2 sends every cycle
  task automatic drive_cycle(input bit do_start, input bit do_stop, input int mode);
    logic [31:0] r;
    @(negedge clk);
    rng = next_random(rng);
    r = rng;
    start = do_start;
    stop  = do_stop;
    case (mode)
      0:       sample_valid = 1'b0;
      1:       sample_valid = (r[1:0] != 2'b00);
      default: sample_valid = 1'b1;
    endcase
    sample_data = r[27:16];
    // about 30 % of cycles with out_ready low
    out_ready = (r[15:8] >= 8'd77);
  endtask

  task automatic run_record(input int kind);
    int target;
    int len;
    int gap;
    int mode;
    target = records_done + 1;
    rng = next_random(rng);
    len = rng % 48;
    gap = (rng >> 8) % 8;
    mode = (kind == KIND_FULL) ? 2 : 1;
    channel_id = rng[23:20];
    if (kind == KIND_EMPTY) begin
      drive_cycle(1'b1, 1'b0, 0);
      drive_cycle(1'b0, 1'b1, 0);
    end else if (kind == KIND_FULL) begin
      // samples keep coming after the bank fills and no stop is sent
      drive_cycle(1'b1, 1'b0, 2);
    end else begin
      drive_cycle(1'b1, 1'b0, 1);
      repeat (len) drive_cycle(1'b0, 1'b0, 1);
      drive_cycle(1'b0, 1'b1, 1);
    end
    // words finished during readout must be dropped
    while (records_done < target) begin
      drive_cycle(1'b0, 1'b0, mode);
    end
    // idle words must be dropped as well
    repeat (gap) drive_cycle(1'b0, 1'b0, 1);
  endtask

  initial begin
    #(CLK_PERIOD * (NUM_RECORDS * RECORD_CYCLES + 20));
    $display("timeout: the records did not complete in the allowed time");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int k;
    reset        = 1'b1;
    start        = 1'b0;
    stop         = 1'b0;
    channel_id   = '0;
    sample_valid = 1'b0;
    sample_data  = '0;
    out_ready    = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    run_record(KIND_STOP);
    run_record(KIND_FULL);
    run_record(KIND_EMPTY);
    repeat (NUM_RANDOM) begin
      rng = next_random(rng);
      k = rng % 8;
      if (k == 0) begin
        run_record(KIND_FULL);
      end else if (k == 1) begin
        run_record(KIND_EMPTY);
      end else begin
        run_record(KIND_STOP);
      end
    end

    // stray beats after the last record reach the monitor here
    repeat (2 * `READ_CREDITS) drive_cycle(1'b0, 1'b0, 1);
    $display("TEST OK");
    $finish;
  end

endmodule
